// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_dual_core
FILELIST  := project.f
OBJDIR    := obj_dir
COMMON    := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINTFLAGS := --lint-only $(COMMON)
SIMFLAGS  := --binary -j 0 --Mdir $(OBJDIR) $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS)

sim:
	$(VERILATOR) $(SIMFLAGS)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== core_pkg.sv ====
package core_pkg;

    // ------------------------------------------------
    // Data path
    // ------------------------------------------------
    localparam int WORD_W    = 16;
    localparam int REG_COUNT = 8;

    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [15:0]                  instr_t;    // op[15:12] rd[11:9] rn[8:6] rm[5:3]
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_MOVI = 4'h1,   // rd = zero-extended imm[7:0]
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_XOR  = 4'h6,
        OP_CMP  = 4'h7    // Flags only
    } opcode_t;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
    } flags_t;

    // ------------------------------------------------
    // Debug port map
    // ------------------------------------------------
    localparam int DBG_ADDR_W = 8;
    localparam int DBG_DATA_W = 32;

    localparam logic [DBG_ADDR_W-1:0] DBG_REG_BASE = 8'h00;   // Register i at 4*i
    localparam logic [DBG_ADDR_W-1:0] DBG_FLAGS    = 8'h20;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== debug_axil.sv ====
module debug_axil import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [DBG_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [DBG_DATA_W-1:0]   wdata,
    input  logic [DBG_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output resp_t                   bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [DBG_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [DBG_DATA_W-1:0]   rdata,
    output resp_t                   rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  word_t                   reg_rd,
    input  flags_t                  flags,
    output logic                    reg_we,
    output reg_idx_t                reg_wa,
    output word_t                   reg_wd,
    output reg_idx_t                reg_ra
);

    localparam int IDX_LSB = 2;
    localparam int IDX_MSB = IDX_LSB + $bits(reg_idx_t) - 1;

    logic                  wr_ready;
    logic                  wr_hs;
    logic                  wr_ok;
    logic                  rd_busy;
    logic [DBG_ADDR_W-1:0] rd_addr;

    function automatic logic is_reg_addr(input logic [DBG_ADDR_W-1:0] a);
        return (a[DBG_ADDR_W-1:IDX_MSB+1] == DBG_REG_BASE[DBG_ADDR_W-1:IDX_MSB+1])
            && (a[IDX_LSB-1:0] == '0);
    endfunction

    // ------------------------------------------------
    // Write channel
    // ------------------------------------------------
    assign awready = wr_ready;
    assign wready  = wr_ready;
    assign wr_hs   = wr_ready && awvalid && wvalid;
    assign wr_ok   = is_reg_addr(awaddr) && (&wstrb[WORD_W/8-1:0]);   // Whole word only

    assign reg_we = wr_hs && wr_ok;
    assign reg_wa = awaddr[IDX_MSB:IDX_LSB];
    assign reg_wd = wdata[WORD_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= RESP_OKAY;
        end else begin
            wr_ready <= awvalid && wvalid && !wr_ready && !bvalid;   // One-cycle pulse
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------
    // Read channel
    // ------------------------------------------------
    assign arready = !rd_busy && !rvalid;
    assign reg_ra  = rd_addr[IDX_MSB:IDX_LSB];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rd_busy <= arvalid && arready;
            if (rd_busy) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
        // Sampled one cycle after accept, from the latched address
        if (rd_busy) begin
            if (is_reg_addr(rd_addr)) begin
                rdata <= {{(DBG_DATA_W - WORD_W){1'b0}}, reg_rd};
                rresp <= RESP_OKAY;
            end else if (rd_addr == DBG_FLAGS) begin
                rdata <= {{(DBG_DATA_W - $bits(flags_t)){1'b0}}, flags};
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
    end

endmodule

// ==== dual_core_props.sv ====
module dual_core_props import core_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  bvalid,
    input logic                  bready,
    input resp_t                 bresp,
    input logic                  rvalid,
    input logic                  rready,
    input logic [DBG_DATA_W-1:0] rdata,
    input resp_t                 rresp
);

    // ------------------------------------------------
    // Response channels hold until accepted
    // ------------------------------------------------
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid or bresp changed while waiting for bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid, rdata or rresp changed while waiting for rready");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !bvalid && !rvalid)
        else $error("response valid in the cycle after reset");

endmodule

bind debug_axil dual_core_props u_props (
    .clk    (clk),
    .rst    (rst),
    .bvalid (bvalid),
    .bready (bready),
    .bresp  (bresp),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rresp  (rresp)
);

// ==== dual_core_top.sv ====
module dual_core_top import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  instr_t                  instr0,
    input  instr_t                  instr1,
    input  logic [DBG_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [DBG_DATA_W-1:0]   wdata,
    input  logic [DBG_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output resp_t                   bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [DBG_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [DBG_DATA_W-1:0]   rdata,
    output resp_t                   rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    // Operand slots: 0 lane0 rn, 1 lane0 rm, 2 lane1 rn, 3 lane1 rm
    reg_idx_t   src_idx [4];
    word_t      src_reg [4];
    word_t      src_val [4];

    // ------------------------------------------------
    // Per-lane stage results, indexed by lane
    // ------------------------------------------------
    word_t      ex_result [2];
    word_t      ps_result [2];
    word_t      wb_result [2];
    reg_idx_t   ex_rd [2];
    reg_idx_t   ps_rd [2];
    reg_idx_t   wb_rd [2];
    logic [1:0] ex_we;
    logic [1:0] ps_we;
    logic [1:0] wb_we;
    flags_t     wb_flags [2];
    logic [1:0] wb_flags_set;

    // Debug side of the register file and flags
    logic       reg_we;
    reg_idx_t   reg_wa;
    word_t      reg_wd;
    reg_idx_t   reg_ra;
    word_t      reg_rd;
    flags_t     flags;

    issue_lane lane0 (
        .clk (clk), .rst (rst), .valid_in (issue_valid), .instr (instr0),
        .rn_val (src_val[0]), .rm_val (src_val[1]),
        .rn_idx (src_idx[0]), .rm_idx (src_idx[1]),
        .ex_result (ex_result[0]), .ex_rd (ex_rd[0]), .ex_we (ex_we[0]),
        .ps_result (ps_result[0]), .ps_rd (ps_rd[0]), .ps_we (ps_we[0]),
        .wb_result (wb_result[0]), .wb_rd (wb_rd[0]), .wb_we (wb_we[0]),
        .wb_flags (wb_flags[0]), .wb_flags_set (wb_flags_set[0])
    );

    issue_lane lane1 (
        .clk (clk), .rst (rst), .valid_in (issue_valid), .instr (instr1),
        .rn_val (src_val[2]), .rm_val (src_val[3]),
        .rn_idx (src_idx[2]), .rm_idx (src_idx[3]),
        .ex_result (ex_result[1]), .ex_rd (ex_rd[1]), .ex_we (ex_we[1]),
        .ps_result (ps_result[1]), .ps_rd (ps_rd[1]), .ps_we (ps_we[1]),
        .wb_result (wb_result[1]), .wb_rd (wb_rd[1]), .wb_we (wb_we[1]),
        .wb_flags (wb_flags[1]), .wb_flags_set (wb_flags_set[1])
    );

    // Same candidate set for every operand slot
    for (genvar g = 0; g < 4; g++) begin : g_fwd
        operand_forward u_fwd (
            .idx (src_idx[g]), .reg_val (src_reg[g]),
            .ex1_val (ex_result[1]), .ex1_rd (ex_rd[1]), .ex1_we (ex_we[1]),
            .ex0_val (ex_result[0]), .ex0_rd (ex_rd[0]), .ex0_we (ex_we[0]),
            .ps1_val (ps_result[1]), .ps1_rd (ps_rd[1]), .ps1_we (ps_we[1]),
            .ps0_val (ps_result[0]), .ps0_rd (ps_rd[0]), .ps0_we (ps_we[0]),
            .wb1_val (wb_result[1]), .wb1_rd (wb_rd[1]), .wb1_we (wb_we[1]),
            .wb0_val (wb_result[0]), .wb0_rd (wb_rd[0]), .wb0_we (wb_we[0]),
            .value (src_val[g])
        );
    end

    regfile_2w u_regfile (
        .clk (clk), .rst (rst),
        .rd_idx0a (src_idx[0]), .rd_idx0b (src_idx[1]),
        .rd_idx1a (src_idx[2]), .rd_idx1b (src_idx[3]),
        .rd_val0a (src_reg[0]), .rd_val0b (src_reg[1]),
        .rd_val1a (src_reg[2]), .rd_val1b (src_reg[3]),
        .we0 (wb_we[0]), .wa0 (wb_rd[0]), .wd0 (wb_result[0]),
        .we1 (wb_we[1]), .wa1 (wb_rd[1]), .wd1 (wb_result[1]),
        .dbg_we (reg_we), .dbg_wa (reg_wa), .dbg_wd (reg_wd),
        .dbg_ra (reg_ra), .dbg_rd (reg_rd)
    );

    flag_tracker u_flags (
        .clk (clk), .rst (rst),
        .set0 (wb_flags_set[0]), .flags0 (wb_flags[0]),
        .set1 (wb_flags_set[1]), .flags1 (wb_flags[1]),
        .flags (flags)
    );

    // AXI4-Lite ports and the debug nets share names with the block
    debug_axil u_debug (.*);

endmodule

// ==== flag_tracker.sv ====
module flag_tracker import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   set0,
    input  flags_t flags0,
    input  logic   set1,
    input  flags_t flags1,
    output flags_t flags
);

    // Lane 1 holds the younger instruction of a pair
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (set1) begin
            flags <= flags1;
        end else if (set0) begin
            flags <= flags0;
        end
    end

endmodule

// ==== issue_lane.sv ====
module issue_lane import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_in,
    input  instr_t   instr,
    input  word_t    rn_val,
    input  word_t    rm_val,
    output reg_idx_t rn_idx,
    output reg_idx_t rm_idx,
    output word_t    ex_result,
    output word_t    ps_result,
    output word_t    wb_result,
    output reg_idx_t ex_rd,
    output reg_idx_t ps_rd,
    output reg_idx_t wb_rd,
    output logic     ex_we,
    output logic     ps_we,
    output logic     wb_we,
    output flags_t   wb_flags,
    output logic     wb_flags_set
);

    localparam int MSB = WORD_W - 1;

    logic    d_valid;
    instr_t  d_instr;
    opcode_t d_op;
    logic    d_we;
    logic    d_fset;

    opcode_t e_op;
    word_t   e_a;
    word_t   e_b;
    logic    e_fset;
    word_t   sum;
    word_t   diff;
    flags_t  alu_flags;

    logic    ps_fset;
    flags_t  ps_flags;

    // ------------------------------------------------
    // Decode and register read
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        d_instr <= instr;
    end

    assign d_op   = opcode_t'(d_instr[15:12]);
    assign rn_idx = d_instr[8:6];
    assign rm_idx = d_instr[5:3];

    always_comb begin
        d_we   = 1'b0;
        d_fset = 1'b0;
        case (d_op)
            OP_MOVI, OP_AND, OP_OR, OP_XOR: d_we = d_valid;
            OP_ADD, OP_SUB: begin
                d_we   = d_valid;
                d_fset = d_valid;
            end
            OP_CMP:  d_fset = d_valid;
            default: ;   // NOP and spare opcodes
        endcase
    end

    // ------------------------------------------------
    // Execute
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_we  <= 1'b0;
            e_fset <= 1'b0;
        end else begin
            ex_we  <= d_we;
            e_fset <= d_fset;
        end
    end

    always_ff @(posedge clk) begin
        e_op  <= d_op;
        ex_rd <= d_instr[11:9];
        e_a   <= rn_val;
        e_b   <= (d_op == OP_MOVI) ? {{(WORD_W - 8){1'b0}}, d_instr[7:0]} : rm_val;
    end

    assign sum  = e_a + e_b;
    assign diff = e_a - e_b;

    always_comb begin
        ex_result   = e_b;   // MOVI passes the immediate
        alu_flags.v = 1'b0;
        case (e_op)
            OP_ADD: begin
                ex_result   = sum;
                alu_flags.v = (e_a[MSB] == e_b[MSB]) && (sum[MSB] != e_a[MSB]);
            end
            OP_SUB, OP_CMP: begin
                ex_result   = diff;
                alu_flags.v = (e_a[MSB] != e_b[MSB]) && (diff[MSB] != e_a[MSB]);
            end
            OP_AND:  ex_result = e_a & e_b;
            OP_OR:   ex_result = e_a | e_b;
            OP_XOR:  ex_result = e_a ^ e_b;
            default: ;
        endcase
        alu_flags.n = ex_result[MSB];
        alu_flags.z = (ex_result == '0);
    end

    // ------------------------------------------------
    // Pass and writeback
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ps_we        <= 1'b0;
            ps_fset      <= 1'b0;
            wb_we        <= 1'b0;
            wb_flags_set <= 1'b0;
        end else begin
            ps_we        <= ex_we;
            ps_fset      <= e_fset;
            wb_we        <= ps_we;
            wb_flags_set <= ps_fset;
        end
    end

    always_ff @(posedge clk) begin
        ps_result <= ex_result;
        ps_rd     <= ex_rd;
        ps_flags  <= alu_flags;
        wb_result <= ps_result;
        wb_rd     <= ps_rd;
        wb_flags  <= ps_flags;
    end

endmodule

// ==== operand_forward.sv ====
module operand_forward import core_pkg::*; (
    input  reg_idx_t idx,
    input  word_t    reg_val,
    input  word_t    ex1_val,
    input  reg_idx_t ex1_rd,
    input  logic     ex1_we,
    input  word_t    ex0_val,
    input  reg_idx_t ex0_rd,
    input  logic     ex0_we,
    input  word_t    ps1_val,
    input  reg_idx_t ps1_rd,
    input  logic     ps1_we,
    input  word_t    ps0_val,
    input  reg_idx_t ps0_rd,
    input  logic     ps0_we,
    input  word_t    wb1_val,
    input  reg_idx_t wb1_rd,
    input  logic     wb1_we,
    input  word_t    wb0_val,
    input  reg_idx_t wb0_rd,
    input  logic     wb0_we,
    output word_t    value
);

    localparam int N_CAND = 6;

    word_t             cand_val [N_CAND];
    reg_idx_t          cand_rd  [N_CAND];
    logic [N_CAND-1:0] cand_we;

    // Entry 0 is the newest result
    assign cand_val = '{ex1_val, ex0_val, ps1_val, ps0_val, wb1_val, wb0_val};
    assign cand_rd  = '{ex1_rd, ex0_rd, ps1_rd, ps0_rd, wb1_rd, wb0_rd};
    assign cand_we  = {wb0_we, wb1_we, ps0_we, ps1_we, ex0_we, ex1_we};

    always_comb begin
        value = reg_val;
        // Walk oldest to newest so the newest match lands last
        for (int i = N_CAND - 1; i >= 0; i--) begin
            if (cand_we[i] && cand_rd[i] == idx) begin
                value = cand_val[i];
            end
        end
    end

endmodule

// ==== project.f ====
core_pkg.sv
regfile_2w.sv
operand_forward.sv
issue_lane.sv
flag_tracker.sv
debug_axil.sv
dual_core_top.sv
dual_core_props.sv
tb_dual_core.sv

// ==== regfile_2w.sv ====
module regfile_2w import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd_idx0a,
    input  reg_idx_t rd_idx0b,
    input  reg_idx_t rd_idx1a,
    input  reg_idx_t rd_idx1b,
    output word_t    rd_val0a,
    output word_t    rd_val0b,
    output word_t    rd_val1a,
    output word_t    rd_val1b,
    input  logic     we0,
    input  reg_idx_t wa0,
    input  word_t    wd0,
    input  logic     we1,
    input  reg_idx_t wa1,
    input  word_t    wd1,
    input  logic     dbg_we,
    input  reg_idx_t dbg_wa,
    input  word_t    dbg_wd,
    input  reg_idx_t dbg_ra,
    output word_t    dbg_rd
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Last write wins, so lane 1 beats lane 0 beats debug
            if (dbg_we) begin
                regs[dbg_wa] <= dbg_wd;
            end
            if (we0) begin
                regs[wa0] <= wd0;
            end
            if (we1) begin
                regs[wa1] <= wd1;
            end
        end
    end

    assign rd_val0a = regs[rd_idx0a];
    assign rd_val0b = regs[rd_idx0b];
    assign rd_val1a = regs[rd_idx1a];
    assign rd_val1b = regs[rd_idx1b];
    assign dbg_rd   = regs[dbg_ra];

endmodule

// ==== tb_dual_core.sv ====
module tb_dual_core import core_pkg::*; ();

    localparam int TIMEOUT = 100;   // Cycles per handshake wait

    logic                    clk;
    logic                    rst;
    logic                    issue_valid;
    instr_t                  instr0;
    instr_t                  instr1;
    logic [DBG_ADDR_W-1:0]   awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [DBG_DATA_W-1:0]   wdata;
    logic [DBG_DATA_W/8-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    resp_t                   bresp;
    logic                    bvalid;
    logic                    bready;
    logic [DBG_ADDR_W-1:0]   araddr;
    logic                    arvalid;
    logic                    arready;
    logic [DBG_DATA_W-1:0]   rdata;
    resp_t                   rresp;
    logic                    rvalid;
    logic                    rready;

    integer seed = 49645;
    word_t  m_regs [REG_COUNT];   // Architectural state of the model
    flags_t m_flags;

    dual_core_top dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ------------------------------------------------
    // Checking and stimulus helpers
    // ------------------------------------------------
    task automatic fail_now();
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            fail_now();
        end
    endtask

    function automatic word_t rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // Cycles a response waits before the master accepts it
    function automatic int response_delay();
        logic [31:0] r;
        r = $random(seed);
        return 1 + int'(r[1:0]);
    endfunction

    function automatic logic [7:0] reg_addr(input int i);
        return DBG_REG_BASE + 8'(4 * i);
    endfunction

    function automatic instr_t enc_rrr(input opcode_t op, input int rd, input int rn,
                                       input int rm);
        return {op, rd[2:0], rn[2:0], rm[2:0], 3'b000};
    endfunction

    function automatic instr_t enc_movi(input int rd, input int imm);
        return {OP_MOVI, rd[2:0], 1'b0, imm[7:0]};
    endfunction

    function automatic logic writes_reg(input instr_t ins);
        return (ins[15:12] >= 4'h1) && (ins[15:12] <= 4'h6);
    endfunction

    // Sources steered off one register so a pair stays independent
    function automatic instr_t rand_instr(input int avoid, input logic avoid_en);
        logic [31:0] r;
        int          rn;
        int          rm;
        r  = $random(seed);
        rn = int'(r[8:6]);
        rm = int'(r[5:3]);
        if (avoid_en && rn == avoid) begin
            rn = (rn + 1) % REG_COUNT;
        end
        if (avoid_en && rm == avoid) begin
            rm = (rm + 1) % REG_COUNT;
        end
        if ({1'b0, r[14:12]} == OP_MOVI) begin
            return enc_movi(int'(r[11:9]), int'(r[23:16]));
        end
        return {1'b0, r[14:9], rn[2:0], rm[2:0], r[2:0]};
    endfunction

    task automatic model_exec(input instr_t ins);
        opcode_t op;
        word_t   a;
        word_t   b;
        word_t   res;
        int      s;
        logic    wr;
        logic    fs;
        op  = opcode_t'(ins[15:12]);
        a   = m_regs[ins[8:6]];
        b   = m_regs[ins[5:3]];
        wr  = 1'b1;
        fs  = 1'b0;
        s   = 0;
        res = '0;
        case (op)
            OP_MOVI: res = {8'h00, ins[7:0]};
            OP_ADD, OP_SUB, OP_CMP: begin
                if (op == OP_ADD) begin
                    s = int'($signed(a)) + int'($signed(b));
                end else begin
                    s = int'($signed(a)) - int'($signed(b));
                end
                res = s[15:0];
                fs  = 1'b1;
                wr  = (op != OP_CMP);
            end
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            default: wr = 1'b0;
        endcase
        if (wr) begin
            m_regs[ins[11:9]] = res;
        end
        if (fs) begin
            m_flags = {res[15], res == 16'h0000, (s > 32767) || (s < -32768)};
        end
    endtask

    // ------------------------------------------------
    // AXI4-Lite and issue port tasks
    // ------------------------------------------------
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output resp_t resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: write address and data were never accepted");
                fail_now();
            end
        end
        @(negedge clk);   // Handshake on the edge in between
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: no write response arrived");
                fail_now();
            end
        end
        repeat (response_delay()) @(negedge clk);   // Response waits for bready
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output resp_t resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: read address was never accepted");
                fail_now();
            end
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: no read data arrived");
                fail_now();
            end
        end
        repeat (response_delay()) @(negedge clk);   // Read data waits for rready
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic issue_pair(input instr_t i0, input instr_t i1);
        @(negedge clk);
        issue_valid = 1'b1;
        instr0      = i0;
        instr1      = i1;
        model_exec(i0);   // Lane 0 first, lane 1 is the younger one
        model_exec(i1);
    endtask

    task automatic issue_idle(input instr_t i0, input instr_t i1);
        @(negedge clk);
        issue_valid = 1'b0;
        instr0      = i0;
        instr1      = i1;
    endtask

    task automatic drain();
        repeat (4) issue_idle('0, '0);
    endtask

    task automatic load_reg(input int i, input word_t val);
        resp_t resp;
        axil_write(reg_addr(i), {16'h0000, val}, resp);
        check_word("bresp", 32'(resp), 32'(RESP_OKAY));
        m_regs[i] = val;
    endtask

    task automatic check_regs();
        logic [31:0] data;
        resp_t       resp;
        for (int i = 0; i < REG_COUNT; i++) begin
            axil_read(reg_addr(i), data, resp);
            check_word($sformatf("rresp reg%0d", i), 32'(resp), 32'(RESP_OKAY));
            check_word($sformatf("rdata reg%0d", i), data, {16'h0000, m_regs[i]});
        end
    endtask

    task automatic check_flags();
        logic [31:0] data;
        resp_t       resp;
        axil_read(DBG_FLAGS, data, resp);
        check_word("rresp flags", 32'(resp), 32'(RESP_OKAY));
        check_word("rdata flags", data, {29'h0, m_flags});
    endtask

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic test_debug_access();
        logic [31:0] data;
        resp_t       resp;
        for (int i = 0; i < REG_COUNT; i++) begin
            load_reg(i, rand_word());
        end
        check_regs();
        axil_write(DBG_FLAGS, 32'h0000_0007, resp);
        check_word("bresp flags", 32'(resp), 32'(RESP_SLVERR));
        check_flags();
        axil_write(8'h40, 32'h0000_1234, resp);
        check_word("bresp 0x40", 32'(resp), 32'(RESP_SLVERR));
        axil_read(8'h40, data, resp);
        check_word("rresp 0x40", 32'(resp), 32'(RESP_SLVERR));
        check_word("rdata 0x40", data, 32'h0);
        check_regs();   // Unmapped write must not alias reg0
    endtask

    task automatic test_independent_pairs();
        issue_pair(enc_movi(0, 'h3c), enc_movi(1, 'hc5));
        issue_pair(enc_movi(2, 'h81), enc_movi(3, 'h07));
        drain();
        issue_pair(enc_rrr(OP_ADD, 4, 0, 1), enc_rrr(OP_SUB, 5, 2, 3));
        drain();
        issue_pair(enc_rrr(OP_AND, 6, 0, 1), enc_rrr(OP_OR, 7, 2, 3));
        drain();
        issue_pair(enc_rrr(OP_XOR, 0, 1, 2), enc_rrr(OP_SUB, 1, 3, 2));
        drain();
        check_regs();
    endtask

    task automatic test_forwarding();
        for (int i = 0; i < REG_COUNT; i += 2) begin
            issue_pair(enc_movi(i, int'(rand_word())), enc_movi(i + 1, int'(rand_word())));
        end
        drain();
        // Back to back, sources 1 to 3 pairs old in both lanes
        issue_pair(enc_rrr(OP_ADD, 0, 1, 2), enc_rrr(OP_SUB, 3, 4, 5));
        issue_pair(enc_rrr(OP_XOR, 1, 0, 3), enc_rrr(OP_ADD, 4, 3, 0));
        issue_pair(enc_rrr(OP_SUB, 2, 1, 0), enc_rrr(OP_OR, 5, 4, 3));
        issue_pair(enc_rrr(OP_ADD, 6, 0, 2), enc_rrr(OP_XOR, 7, 3, 1));
        issue_pair(enc_rrr(OP_ADD, 0, 4, 5), enc_rrr(OP_SUB, 3, 6, 1));
        issue_pair(enc_rrr(OP_AND, 1, 7, 0), enc_rrr(OP_ADD, 4, 2, 3));
        drain();
        check_regs();
        check_flags();
    endtask

    task automatic test_same_destination();
        issue_pair(enc_movi(2, 'h11), enc_movi(2, 'h22));
        issue_pair(enc_rrr(OP_ADD, 5, 2, 2), enc_rrr(OP_NOP, 0, 0, 0));
        issue_pair(enc_rrr(OP_XOR, 6, 5, 2), enc_rrr(OP_SUB, 6, 5, 2));
        drain();
        check_regs();
    endtask

    task automatic test_flags();
        load_reg(0, 16'h7fff);
        load_reg(1, 16'h0001);
        load_reg(2, 16'h8000);
        load_reg(3, 16'h0005);
        issue_pair(enc_rrr(OP_CMP, 0, 3, 3), '0);   // Zero, lane 0 alone
        drain();
        check_flags();
        issue_pair(enc_rrr(OP_CMP, 0, 3, 1), enc_rrr(OP_CMP, 0, 2, 1));
        drain();
        check_flags();
        issue_pair(enc_rrr(OP_CMP, 0, 1, 3), '0);   // Negative
        drain();
        check_flags();
        issue_pair(enc_rrr(OP_AND, 4, 0, 1), enc_rrr(OP_XOR, 5, 3, 3));
        drain();
        check_flags();
        issue_pair(enc_rrr(OP_ADD, 6, 0, 1), '0);   // Positive overflow
        drain();
        check_flags();
        issue_pair(enc_rrr(OP_SUB, 7, 1, 1), enc_rrr(OP_OR, 4, 3, 3));
        drain();
        check_flags();
        check_regs();
    endtask

    task automatic test_random_stream();
        logic [31:0] r;
        instr_t      i0;
        instr_t      i1;
        for (int k = 0; k < 200; k++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                issue_idle(rand_word(), rand_word());   // Junk with valid low
            end else begin
                i0 = rand_instr(0, 1'b0);
                i1 = rand_instr(int'(i0[11:9]), writes_reg(i0));
                issue_pair(i0, i1);
            end
        end
        drain();
        check_regs();
        check_flags();
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        instr0      = '0;
        instr1      = '0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        for (int i = 0; i < REG_COUNT; i++) begin
            m_regs[i] = '0;
        end
        m_flags = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_debug_access();
        test_independent_pairs();
        test_forwarding();
        test_same_destination();
        test_flags();
        test_random_stream();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        repeat (20000) @(posedge clk);
        $display("Timeout: the run did not finish in time");
        fail_now();
    end

endmodule
